// File: rtl/ethFramePkg.sv
// Ethernet frame constants; FCS math assumes the MSB-first CRC step fed with bit-reversed bytes
`default_nettype none

package ethFramePkg;

    // ------------------------------
    // Frame delimiters
    // ------------------------------
    localparam logic [7:0] preambleByte = 8'h55;    // Alternating 1/0 pattern
    localparam logic [7:0] sfdByte      = 8'hD5;    // Start-of-frame delimiter
    localparam logic [2:0] preambleLen  = 3'd7;     // Preamble bytes before the SFD

    // ------------------------------
    // Size limits
    // ------------------------------
    // 64-byte minimum frame less the 4 FCS bytes
    localparam logic [5:0] minPayload   = 6'd60;
    localparam logic [2:0] fcsLen       = 3'd4;     // FCS bytes after payload and padding

    // ------------------------------
    // CRC-32
    // ------------------------------
    localparam logic [31:0] crcInit     = 32'hFFFF_FFFF;  // Start value before the first byte
    localparam logic [31:0] crcPoly     = 32'h04C1_1DB7;  // IEEE 802.3 polynomial, normal form

endpackage : ethFramePkg

`default_nettype wire

// File: rtl/ethCtrlPkg.sv
// Receive and transmit FSM codes; endGap assumes the switch never pauses RxValid 3 cycles mid-frame
`default_nettype none

package ethCtrlPkg;

    // ------------------------------
    // Receive FSM
    // ------------------------------
    localparam logic [1:0] rxIdle     = 2'd0;   // Preamble or line idle
    localparam logic [1:0] rxFrame    = 2'd1;   // Payload bytes after the SFD
    localparam logic [1:0] rxWaitSend = 2'd2;   // Response owed, port held off
    localparam logic [1:0] rxWaitBw   = 2'd3;   // Block write still running

    // ------------------------------
    // Transmit FSM
    // ------------------------------
    localparam logic [2:0] txIdle     = 3'd0;
    localparam logic [2:0] txPreamble = 3'd1;   // Seven 0x55 then 0xD5
    localparam logic [2:0] txSend     = 3'd2;   // Payload, low byte first
    localparam logic [2:0] txPadding  = 3'd3;   // Zeros up to the minimum payload
    localparam logic [2:0] txCrc      = 3'd4;   // Four FCS bytes

    // Quiet cycles inside a frame that close it
    localparam logic [1:0] endGap     = 2'd3;

endpackage : ethCtrlPkg

`default_nettype wire

// File: rtl/crc32Byte.sv
// Pure XOR logic with no register; the caller reverses data and result bits to get the reflected CRC
`timescale 1ns/1ps
`default_nettype none

module crc32Byte (
    input  wire  [7:0]  crcData,    // Byte already bit-reversed by the framer
    input  wire  [31:0] crcIn,      // Running CRC register
    output logic [31:0] crcOut      // CRC after this byte
);

    // ------------------------------
    // Eight bit steps, MSB first
    // ------------------------------
    always_comb begin : crcStep
        logic [31:0] crc;
        logic        feedback;

        crc = crcIn;
        for (int i = 7; i >= 0; i--) begin
            feedback = crc[31] ^ crcData[i];                // Top bit meets next data bit
            crc      = {crc[30:0], 1'b0};                   // Shift toward the MSB
            if (feedback) begin
                crc = crc ^ ethFramePkg::crcPoly;           // Divide by the polynomial
            end
        end
        crcOut = crc;
    end

endmodule : crc32Byte

`default_nettype wire

// File: rtl/ethRxDeframer.sv
// Preamble bytes are not checked, only 0xD5 opens a frame; elapsed time saturates at 0xFFFF
`timescale 1ns/1ps
`default_nettype none

module ethRxDeframer (
    input  wire         TxClk,
    input  wire         reset,
    input  wire         RxValid,            // Byte on RxD this cycle
    input  wire  [7:0]  RxD,
    input  wire         recvBusy,           // Engine is taking the packet
    input  wire         responseRequired,
    input  wire         bwActive,           // Block write in progress
    input  wire         txBusy,             // Framer owns the line
    input  wire  [31:0] timestamp,
    input  wire         clearErrors,
    output logic        PortReady,          // Switch may send the next byte
    output logic        recvRequest,
    output logic        recvReady,          // recvWord valid for one cycle
    output logic [15:0] recvWord,
    output logic        sendResponse,       // One-cycle request to the framer
    output logic [15:0] timeReceive,
    output logic [15:0] timeNow,
    output logic        rxError
);

    logic [1:0]  rxState;
    logic        byteOdd;       // Next payload byte fills the low half
    logic [1:0]  gapCnt;        // Cycles without RxValid inside a frame
    logic        respSent;      // Response pulse already issued
    logic        sawBusy;       // Framer went busy after the pulse
    logic [31:0] startTime;     // Timestamp of the first preamble byte
    logic [31:0] elapsed;
    logic        frameByte;     // Payload byte taken this cycle
    logic        frameEnd;      // Last quiet cycle of the gap

    assign frameByte = (rxState == ethCtrlPkg::rxFrame) && RxValid;
    assign frameEnd  = (rxState == ethCtrlPkg::rxFrame) && !RxValid &&
                       (gapCnt == ethCtrlPkg::endGap - 2'd1);

    // ------------------------------
    // Receive time
    // ------------------------------
    assign elapsed = timestamp - startTime;
    assign timeNow = (elapsed[31:16] != 16'd0) ? 16'hFFFF : elapsed[15:0];    // Saturate

    // Data path
    always_ff @(posedge TxClk) begin
        if ((rxState == ethCtrlPkg::rxIdle) && RxValid && !recvRequest) begin
            startTime <= timestamp;                 // First byte of a new frame
        end
        if (frameByte && !byteOdd) begin
            recvWord[15:8] <= RxD;                  // Even byte goes high
        end
        if (frameByte && byteOdd) begin
            recvWord[7:0] <= RxD;
        end
        if (frameEnd && byteOdd) begin
            recvWord[7:0] <= 8'h00;                 // Pad a lone last byte
        end
        if (frameEnd) begin
            timeReceive <= timeNow;
        end
    end

    // ------------------------------
    // Receive FSM
    // ------------------------------
    always_ff @(posedge TxClk) begin
        if (reset) begin
            rxState      <= ethCtrlPkg::rxIdle;
            PortReady    <= 1'b0;
            recvRequest  <= 1'b0;
            recvReady    <= 1'b0;
            sendResponse <= 1'b0;
            rxError      <= 1'b0;
            byteOdd      <= 1'b0;
            gapCnt       <= 2'd0;
            respSent     <= 1'b0;
            sawBusy      <= 1'b0;
        end else begin
            recvReady    <= 1'b0;                   // Strobes idle low
            sendResponse <= 1'b0;
            if (clearErrors) begin
                rxError <= 1'b0;                    // A new error below still wins
            end

            case (rxState)
                ethCtrlPkg::rxIdle: begin
                    PortReady <= 1'b1;
                    if (RxValid) begin
                        recvRequest <= 1'b1;        // Preamble seen
                        if (RxD == ethFramePkg::sfdByte) begin
                            byteOdd <= 1'b0;
                            gapCnt  <= 2'd0;
                            rxState <= ethCtrlPkg::rxFrame;
                            if (!recvBusy) begin
                                rxError <= 1'b1;    // Engine not listening
                            end
                        end
                    end
                end

                ethCtrlPkg::rxFrame: begin
                    if (RxValid) begin
                        recvRequest <= 1'b0;        // Payload has started
                        gapCnt      <= 2'd0;
                        byteOdd     <= ~byteOdd;
                        recvReady   <= byteOdd;     // Odd byte completes a word
                    end else if (frameEnd) begin
                        recvRequest <= 1'b0;        // Covers a frame with no payload
                        recvReady   <= byteOdd;     // Flush the padded word
                        respSent    <= 1'b0;
                        sawBusy     <= 1'b0;
                        if (responseRequired) begin
                            PortReady <= 1'b0;
                            rxState   <= ethCtrlPkg::rxWaitSend;
                        end else if (bwActive) begin
                            PortReady <= 1'b0;
                            rxState   <= ethCtrlPkg::rxWaitBw;
                        end else begin
                            rxState   <= ethCtrlPkg::rxIdle;
                        end
                    end else begin
                        gapCnt <= gapCnt + 2'd1;
                    end
                end

                ethCtrlPkg::rxWaitSend: begin
                    if (!respSent) begin
                        if (!txBusy) begin
                            sendResponse <= 1'b1;   // Single pulse
                            respSent     <= 1'b1;
                        end
                    end else if (txBusy) begin
                        sawBusy <= 1'b1;
                    end else if (sawBusy) begin
                        PortReady <= 1'b1;          // Response is out
                        rxState   <= ethCtrlPkg::rxIdle;
                    end
                end

                ethCtrlPkg::rxWaitBw: begin
                    if (!bwActive) begin
                        PortReady <= 1'b1;
                        rxState   <= ethCtrlPkg::rxIdle;
                    end
                end
            endcase
        end
    end

endmodule : ethRxDeframer

`default_nettype wire

// File: rtl/ethTxFramer.sv
// responseByteCount must be at least 1 and held for the whole frame; no back-pressure once TxEn rises
`timescale 1ns/1ps
`default_nettype none

module ethTxFramer (
    input  wire         TxClk,
    input  wire         reset,
    input  wire         sendReq,            // Forward request, wins over a response
    input  wire         sendResponse,
    input  wire  [15:0] responseByteCount,  // Payload bytes N
    input  wire  [15:0] send_word,          // Valid the cycle after sendReady
    input  wire  [31:0] crcOut,
    output logic        sendRequest,
    output logic        sendReady,
    output logic        isForward,
    output logic        TxEn,
    output logic [7:0]  TxD,
    output logic        txBusy,
    output logic [7:0]  crcData,
    output logic [31:0] crcIn,              // Running CRC register
    output logic        txError
);

    logic [2:0]  txState;
    logic [2:0]  cnt;           // Preamble and FCS byte index
    logic [15:0] byteCnt;       // Bytes after the SFD
    logic        respPending;   // Response waits behind a forward
    logic [7:0]  payByte;
    logic        lastByte;
    logic        lastPad;
    logic        wordAhead;

    function automatic logic [7:0] bitRev(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

    assign payByte   = byteCnt[0] ? send_word[15:8] : send_word[7:0];      // Low byte first
    assign lastByte  = (byteCnt == responseByteCount - 16'd1);
    assign lastPad   = (byteCnt >= {10'd0, ethFramePkg::minPayload} - 16'd1);
    assign wordAhead = (byteCnt + 16'd2 < responseByteCount);             // Another word due
    assign crcData   = (txState == ethCtrlPkg::txSend) ? bitRev(payByte) : 8'h00;

    // CRC register
    always_ff @(posedge TxClk) begin
        if (txState == ethCtrlPkg::txPreamble) begin
            crcIn <= ethFramePkg::crcInit;
        end else if ((txState == ethCtrlPkg::txSend) || (txState == ethCtrlPkg::txPadding)) begin
            crcIn <= crcOut;
        end else if (txState == ethCtrlPkg::txCrc) begin
            crcIn <= {crcIn[23:0], 8'h00};          // Next FCS byte to the top
        end
    end

    // ------------------------------
    // Transmit FSM
    // ------------------------------
    always_ff @(posedge TxClk) begin
        if (reset) begin
            txState     <= ethCtrlPkg::txIdle;
            cnt         <= 3'd0;
            byteCnt     <= 16'd0;
            sendRequest <= 1'b0;
            sendReady   <= 1'b0;
            isForward   <= 1'b0;
            TxEn        <= 1'b0;
            TxD         <= 8'h00;
            txBusy      <= 1'b0;
            respPending <= 1'b0;
            txError     <= 1'b0;
        end else begin
            sendRequest <= 1'b0;
            sendReady   <= 1'b0;

            case (txState)
                ethCtrlPkg::txIdle: begin
                    TxEn    <= 1'b0;
                    TxD     <= 8'h00;
                    cnt     <= 3'd0;
                    byteCnt <= 16'd0;
                    if (sendReq) begin
                        isForward   <= 1'b1;
                        sendRequest <= 1'b1;
                        txBusy      <= 1'b1;
                        txState     <= ethCtrlPkg::txPreamble;
                        if (sendResponse) begin
                            respPending <= 1'b1;    // Goes out after this frame
                        end
                    end else if (sendResponse || (respPending && !TxEn)) begin
                        isForward   <= 1'b0;        // Queued response waits for TxEn to drop
                        sendRequest <= 1'b1;
                        txBusy      <= 1'b1;
                        respPending <= 1'b0;
                        txState     <= ethCtrlPkg::txPreamble;
                    end
                end

                ethCtrlPkg::txPreamble: begin
                    TxEn <= 1'b1;
                    cnt  <= cnt + 3'd1;
                    if (cnt == ethFramePkg::preambleLen) begin
                        TxD     <= ethFramePkg::sfdByte;
                        txState <= ethCtrlPkg::txSend;
                    end else begin
                        TxD <= ethFramePkg::preambleByte;
                    end
                    if (cnt == ethFramePkg::preambleLen - 3'd1) begin
                        sendReady <= 1'b1;          // First word needed after the SFD
                    end
                end

                ethCtrlPkg::txSend: begin
                    TxD     <= payByte;
                    byteCnt <= byteCnt + 16'd1;
                    if (!byteCnt[0]) begin
                        sendReady <= wordAhead;     // Ask one cycle ahead
                    end
                    if (lastByte) begin
                        cnt     <= 3'd0;
                        txState <= lastPad ? ethCtrlPkg::txCrc : ethCtrlPkg::txPadding;
                    end
                end

                ethCtrlPkg::txPadding: begin
                    TxD     <= 8'h00;
                    byteCnt <= byteCnt + 16'd1;
                    if (lastPad) begin
                        txState <= ethCtrlPkg::txCrc;
                    end
                end

                ethCtrlPkg::txCrc: begin
                    TxD <= ~bitRev(crcIn[31:24]);   // FCS in wire order, inverted
                    cnt <= cnt + 3'd1;
                    if (cnt == ethFramePkg::fcsLen - 3'd1) begin
                        txBusy  <= respPending;     // Stay busy for a queued response
                        txState <= ethCtrlPkg::txIdle;
                    end
                end

                default: begin
                    txError <= 1'b1;                // Sticky until reset
                    TxEn    <= 1'b0;
                    txBusy  <= 1'b0;
                    txState <= ethCtrlPkg::txIdle;
                end
            endcase
        end
    end

endmodule : ethTxFramer

`default_nettype wire

// File: rtl/ethRtInterface.sv
// Single clock TxClk for both directions; RxErr and TxErr paths and debug readback are not provided
`timescale 1ns/1ps
`default_nettype none

module ethRtInterface (
    input  wire         TxClk,
    input  wire         reset,
    // GMII side of the switch
    input  wire         RxValid,
    input  wire  [7:0]  RxD,
    output logic        PortReady,
    output logic        TxEn,
    output logic [7:0]  TxD,
    // Packet engine, receive
    input  wire         recvBusy,
    output logic        recvRequest,
    output logic        recvReady,
    output logic [15:0] recvWord,
    input  wire         responseRequired,
    input  wire  [15:0] responseByteCount,
    input  wire         bwActive,
    // Packet engine, send
    input  wire         sendReq,
    output logic        sendRequest,
    output logic        sendReady,
    input  wire  [15:0] send_word,
    output logic        isForward,
    // Timing and errors
    input  wire  [31:0] timestamp,
    output logic [15:0] timeReceive,
    output logic [15:0] timeNow,
    input  wire         clearErrors,
    output logic        internalError
);

    logic        sendResponse;  // Deframer asks for a response frame
    logic        txBusy;
    logic [7:0]  crcData;
    logic [31:0] crcIn;
    logic [31:0] crcOut;
    logic        rxError;
    logic        txError;

    // ------------------------------
    // Receive path
    // ------------------------------
    ethRxDeframer rxPath (
        .TxClk(TxClk),                  .reset(reset),
        .RxValid(RxValid),              .RxD(RxD),
        .recvBusy(recvBusy),            .responseRequired(responseRequired),
        .bwActive(bwActive),            .txBusy(txBusy),
        .timestamp(timestamp),          .clearErrors(clearErrors),
        .PortReady(PortReady),          .recvRequest(recvRequest),
        .recvReady(recvReady),          .recvWord(recvWord),
        .sendResponse(sendResponse),    .timeReceive(timeReceive),
        .timeNow(timeNow),              .rxError(rxError)
    );

    // ------------------------------
    // Transmit path
    // ------------------------------
    ethTxFramer txPath (
        .TxClk(TxClk),                  .reset(reset),
        .sendReq(sendReq),              .sendResponse(sendResponse),
        .responseByteCount(responseByteCount),
        .send_word(send_word),          .crcOut(crcOut),
        .sendRequest(sendRequest),      .sendReady(sendReady),
        .isForward(isForward),          .TxEn(TxEn),
        .TxD(TxD),                      .txBusy(txBusy),
        .crcData(crcData),              .crcIn(crcIn),
        .txError(txError)
    );

    crc32Byte fcsStep (                 // Fed by the framer's CRC register
        .crcData(crcData),
        .crcIn(crcIn),
        .crcOut(crcOut)
    );

    assign internalError = rxError | txError;   // Either side flags the engine

endmodule : ethRtInterface

`default_nettype wire

// File: verif/ethRtAsserts.sv
// Protocol checks on the top level strobes; bound to every ethRtInterface, disabled during reset
`timescale 1ns/1ps
`default_nettype none

module ethRtAsserts (
    input wire TxClk,
    input wire reset,
    input wire TxEn,
    input wire sendRequest,
    input wire sendReady,
    input wire recvReady
);

    // ------------------------------
    // Strobe shape
    // ------------------------------
    sendReadyPulse: assert property (@(posedge TxClk) disable iff (reset)
        sendReady |=> !sendReady)
        else $error("sendReady held for two cycles");

    recvReadyPulse: assert property (@(posedge TxClk) disable iff (reset)
        recvReady |=> !recvReady)
        else $error("recvReady held for two cycles");

    // Line stays quiet at least two cycles between frames
    txEnGap: assert property (@(posedge TxClk) disable iff (reset)
        $fell(TxEn) |=> !TxEn)
        else $error("TxEn rose again one cycle after it fell");

    // Every frame is announced by sendRequest one cycle ahead
    txEnAfterRequest: assert property (@(posedge TxClk) disable iff (reset)
        $rose(TxEn) |-> $past(sendRequest))
        else $error("TxEn rose without a preceding sendRequest");

    // Shortest frame is 8 + 60 + 4 cycles
    txEnMinLength: assert property (@(posedge TxClk) disable iff (reset)
        $fell(TxEn) |-> $past(TxEn, 72))
        else $error("TxEn frame shorter than the minimum");

endmodule : ethRtAsserts

bind ethRtInterface ethRtAsserts rtChecks (
    .TxClk(TxClk),
    .reset(reset),
    .TxEn(TxEn),
    .sendRequest(sendRequest),
    .sendReady(sendReady),
    .recvReady(recvReady)
);

`default_nettype wire

// File: verif/ethRtTb.sv
// Random frames from a fixed seed; the engine model must finish each transmit before the next frame
`timescale 1ns/1ps
`default_nettype none

module ethRtTb;

    localparam int          frameCount = 20;
    localparam int          clkPeriod  = 4;
    localparam logic [31:0] seed       = 32'h0613_e61b;

    logic        TxClk = 1'b0;
    logic        reset;
    logic        RxValid, recvBusy, responseRequired, bwActive, sendReq, clearErrors;
    logic [7:0]  RxD;
    logic [15:0] responseByteCount, send_word;
    logic [31:0] timestamp;
    logic        PortReady, TxEn, recvRequest, recvReady, sendRequest, sendReady;
    logic        isForward, internalError;
    logic [7:0]  TxD;
    logic [15:0] recvWord, timeReceive, timeNow;

    int          errors = 0;
    int          checks = 0;
    int          tsStep = 1;             // Timestamp increment per cycle
    int          txDone = 0;             // Transmit frames seen by the monitor
    int          txTarget = 0;           // Transmit frames expected so far
    int          reqCount = 0;           // sendRequest pulses seen
    logic        captureStart = 1'b0;    // Latch timestamp at next RxValid
    logic [31:0] tsStart;
    logic [15:0] rxWords[$];             // Words delivered on recvWord
    logic [7:0]  wordBytes[$];           // Bytes handed out on send_word, low first
    logic [7:0]  txBytes[$];             // Bytes seen on TxD under TxEn
    logic        expFwd[$];              // Expected isForward per frame
    logic        frameFwd;

    ethRtInterface dut (.*);

    always #(clkPeriod / 2) TxClk = ~TxClk;

    // ------------------------------
    // Checking helpers
    // ------------------------------
    task automatic compareValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Reflected CRC-32, one byte, LSB first
    function automatic logic [31:0] crcStepRef(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic checkTxFrame();
        logic [7:0]  expBytes[$];
        logic [31:0] crc;
        int          n;
        n = responseByteCount;
        repeat (7) expBytes.push_back(8'h55);
        expBytes.push_back(8'hD5);
        compareValue("txWordsFetched", 2 * ((n + 1) / 2), wordBytes.size());
        for (int i = 0; i < n; i++) begin
            expBytes.push_back((i < wordBytes.size()) ? wordBytes[i] : 8'h00);
        end
        while (expBytes.size() < 8 + ethFramePkg::minPayload) begin
            expBytes.push_back(8'h00);          // Zero padding
        end
        crc = 32'hFFFF_FFFF;
        for (int i = 8; i < expBytes.size(); i++) begin
            crc = crcStepRef(crc, expBytes[i]);
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            expBytes.push_back(crc[8*k +: 8]);  // FCS LSB first
        end
        compareValue("txLength", expBytes.size(), txBytes.size());
        for (int i = 0; i < expBytes.size() && i < txBytes.size(); i++) begin
            compareValue($sformatf("txByte%0d", i), expBytes[i], txBytes[i]);
        end
        if (expFwd.size() == 0) begin
            errors++;
            $display("A transmit frame appeared that no request asked for");
        end else begin
            compareValue("isForward", expFwd.pop_front(), frameFwd);
        end
    endtask

    // ------------------------------
    // Models and monitors
    // ------------------------------
    always @(posedge TxClk) begin
        #0.5;
        timestamp = timestamp + tsStep;         // Free-running counter
    end

    always @(posedge TxClk) begin : engineWords
        logic [15:0] w;
        if (sendReady) begin
            w = $urandom;
            wordBytes.push_back(w[7:0]);
            wordBytes.push_back(w[15:8]);
            #0.5;
            send_word = w;                      // Valid the cycle after sendReady
        end
    end

    always @(posedge TxClk) begin
        if (recvReady) rxWords.push_back(recvWord);
        if (sendRequest) reqCount++;
        if (RxValid && captureStart) begin
            tsStart      = timestamp;           // First preamble byte
            captureStart = 1'b0;
        end
        if (TxEn) begin
            if (txBytes.size() == 0) frameFwd = isForward;
            txBytes.push_back(TxD);
        end else if (txBytes.size() > 0) begin
            checkTxFrame();                     // TxEn just fell
            txBytes.delete();
            wordBytes.delete();
            txDone++;
        end
    end

    task automatic tick();
        @(posedge TxClk);
        #0.5;
    endtask

    task automatic waitTxDone();
        while (txDone < txTarget) tick();
    endtask

    // ------------------------------
    // Receive one frame and check it
    // ------------------------------
    task automatic sendRxFrame(input int len, input logic errFrame);
        logic [7:0]  pay[$];
        logic [31:0] tsEnd, diff;
        logic [15:0] w;
        rxWords.delete();
        recvBusy     = !errFrame;
        captureStart = 1'b1;
        compareValue("recvRequestIdle", 0, recvRequest);
        for (int k = 0; k < 8 + len; k++) begin
            if ($urandom % 4 == 0) begin
                RxValid = 1'b0;                 // Short gap, below endGap
                repeat ($urandom % 3) tick();
            end
            if (k > 0) compareValue("recvRequestSpan", k <= 8, recvRequest);
            RxValid = 1'b1;
            if (k < 7) RxD = 8'h55;
            else if (k == 7) RxD = 8'hD5;
            else begin
                RxD = $urandom;
                pay.push_back(RxD);
            end
            tick();
        end
        RxValid = 1'b0;
        compareValue("recvRequestPayload", 0, recvRequest);
        repeat (2) @(posedge TxClk);
        @(posedge TxClk);
        tsEnd = timestamp;                      // Frame end edge
        diff  = tsEnd - tsStart;
        compareValue("timeNow", (diff > 32'hFFFF) ? 32'hFFFF : diff, timeNow);
        #0.5;
        compareValue("timeReceive", (diff > 32'hFFFF) ? 32'hFFFF : diff, timeReceive);
        compareValue("recvRequestEnd", 0, recvRequest);
        compareValue("internalError", errFrame, internalError);
        tick();                                 // Padded word lands here
        recvBusy = 1'b0;
        compareValue("rxWordCount", (len + 1) / 2, rxWords.size());
        for (int i = 0; i < (len + 1) / 2 && i < rxWords.size(); i++) begin
            w = {pay[2*i], (2*i + 1 < len) ? pay[2*i + 1] : 8'h00};
            compareValue($sformatf("rxWord%0d", i), w, rxWords[i]);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : mainSeq
        int   mode, len;
        logic seenResp;
        void'($urandom(seed));
        reset = 1'b1;
        {RxValid, recvBusy, responseRequired, bwActive, sendReq, clearErrors} = '0;
        RxD = 8'h00;
        responseByteCount = 16'd1;
        send_word = 16'h0000;
        timestamp = 32'd0;
        repeat (3) @(posedge TxClk);
        #0.5;
        reset = 1'b0;

        for (int f = 0; f < frameCount; f++) begin
            while (!PortReady) tick();
            mode   = (f == 2) ? 0 : $urandom % 4;   // 0 plain, 1 response, 2 bw, 3 both
            len    = 1 + $urandom % 100;
            tsStep = ($urandom % 5 == 0) ? 1500 : 1; // Large steps saturate
            responseByteCount = len;
            responseRequired  = (mode == 1) || (mode == 3);
            bwActive          = (mode == 2);
            sendRxFrame(len, f == 2);
            tsStep = 1;
            if (mode == 3) begin
                sendReq = 1'b1;                 // Lands with the response pulse
                expFwd.push_back(1'b1);
                expFwd.push_back(1'b0);
                txTarget += 2;
                tick();
                sendReq = 1'b0;
            end else if (mode == 1) begin
                expFwd.push_back(1'b0);
                txTarget++;
            end
            if (mode == 1 || mode == 3) begin
                seenResp = 1'b0;
                while (!(seenResp && !TxEn)) begin
                    if (TxEn && !isForward) seenResp = 1'b1;
                    compareValue("portHeldForResponse", 0, PortReady);
                    tick();
                end
                responseRequired = 1'b0;
            end else if (mode == 2) begin
                repeat (1 + $urandom % 10) begin
                    compareValue("portHeldForBw", 0, PortReady);
                    tick();
                end
                bwActive = 1'b0;
                tick();
            end
            waitTxDone();
            compareValue("portReadyAfter", 1, PortReady);
            if (f == 2) begin
                clearErrors = 1'b1;
                tick();
                clearErrors = 1'b0;
                compareValue("internalErrorCleared", 0, internalError);
            end else if (mode == 0 && ($urandom % 2)) begin
                sendReq = 1'b1;                 // Plain forward frame
                expFwd.push_back(1'b1);
                txTarget++;
                tick();
                sendReq = 1'b0;
                waitTxDone();
            end
        end

        compareValue("txFrameCount", txTarget, txDone);
        compareValue("sendRequestCount", txTarget, reqCount);
        $display("Errors %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the frame count
    initial begin
        #(frameCount * 400 * clkPeriod);
        $display("Timeout, the frames did not complete in time, errors so far %0d", errors);
        $display("Regression failed");
        $finish;
    end

endmodule : ethRtTb

`default_nettype wire

// File: build.f
rtl/ethFramePkg.sv
rtl/ethCtrlPkg.sv
rtl/crc32Byte.sv
rtl/ethRxDeframer.sv
rtl/ethTxFramer.sv
rtl/ethRtInterface.sv
verif/ethRtAsserts.sv
verif/ethRtTb.sv

// File: Bender.yml
package:
  name: ethRtInterface

sources:
  - files:
      - rtl/ethFramePkg.sv
      - rtl/ethCtrlPkg.sv
      - rtl/crc32Byte.sv
      - rtl/ethRxDeframer.sv
      - rtl/ethTxFramer.sv
      - rtl/ethRtInterface.sv
  - target: test
    files:
      - verif/ethRtAsserts.sv
      - verif/ethRtTb.sv
